//--- radio_regmap_pkg.sv
`default_nettype none

package radio_regmap_pkg;

    typedef logic [31:0] apb_data_t;
    typedef logic [5:0]  reg_index_t;  // paddr / 4

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        apb_data_t  pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Register word indices
    localparam reg_index_t REG_ID         = 6'h00;
    localparam reg_index_t REG_IRQ        = 6'h02;
    localparam reg_index_t REG_LED_CNTRL  = 6'h10;
    localparam reg_index_t REG_RED_DUTY   = 6'h11;
    localparam reg_index_t REG_GREEN_DUTY = 6'h12;
    localparam reg_index_t REG_BLUE_DUTY  = 6'h13;
    localparam reg_index_t REG_CAP_CNTRL  = 6'h20;
    localparam reg_index_t REG_CAP_ADDR   = 6'h21;
    localparam reg_index_t REG_CAP_DATA   = 6'h22;

    localparam apb_data_t RADIO_ID = 32'hA000_0001;

    localparam int IRQ_MASK0_LSB = 0;
    localparam int IRQ_MASK1_LSB = 8;
    localparam int IRQ_STATE_LSB = 16;  // State on read, clear on write
    localparam int IRQ_SET_LSB   = 24;

    localparam int LED_EN_BIT       = 0;
    localparam int CAP_TRIG_BIT     = 0;
    localparam int CAP_AUTO_INC_BIT = 1;
    localparam int CAP_BUSY_BIT     = 2;  // Read only
    localparam int CAP_RD_ADDR_LSB  = 0;
    localparam int CAP_WR_ADDR_LSB  = 16;

endpackage

`default_nettype wire

//--- radio_signal_pkg.sv
`default_nettype none

package radio_signal_pkg;

    typedef struct packed {
        logic        overflow;
        logic [15:0] data;
    } adc_sample_t;

    typedef logic [15:0] buf_addr_t;

    typedef struct packed {
        logic      busy;
        buf_addr_t wr_addr;
    } cap_status_t;

    localparam int LED_DUTY_WIDTH = 12;

    typedef struct packed {
        logic                      enable;
        logic [LED_DUTY_WIDTH-1:0] red_duty;
        logic [LED_DUTY_WIDTH-1:0] green_duty;
        logic [LED_DUTY_WIDTH-1:0] blue_duty;
    } led_cfg_t;

    localparam int IRQ_COUNT = 8;

    typedef logic [IRQ_COUNT-1:0] irq_vec_t;

    // Set and clear are single-cycle requests
    typedef struct packed {
        irq_vec_t mask0;    // Drives smc_irq_n
        irq_vec_t mask1;    // Drives dsp_irq_n
        irq_vec_t set_req;
        irq_vec_t clr_req;
    } irq_cfg_t;

endpackage

`default_nettype wire

//--- adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture
    import radio_signal_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 12
)
(
    input  wire         led_clk,
    input  wire         adc_dpram_rst,
    input  wire  [15:0] adc_data,
    input  wire         adc_of,
    input  wire         trig,
    output logic        adc_clk_en,
    output logic        wr_en,
    output buf_addr_t   wr_addr,
    output adc_sample_t wr_sample,
    output cap_status_t status
);
    localparam int DEPTH = 1 << BUF_ADDR_WIDTH;

    adc_sample_t               sample_q;
    logic                      busy_q;
    logic [BUF_ADDR_WIDTH-1:0] fill_cnt;

    // Pin sampling, one cycle to the buffer input
    always_ff @(posedge led_clk)
    begin
        sample_q <= '{overflow: adc_of, data: adc_data};
    end

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            adc_clk_en <= 1'b0;
            busy_q     <= 1'b0;
            fill_cnt   <= '0;
        end
        else
        begin
            adc_clk_en <= 1'b1;
            if (!busy_q)
            begin
                fill_cnt <= '0;
                if (trig)
                    busy_q <= 1'b1;  // Ignored while a fill runs
            end
            else
            begin
                fill_cnt <= fill_cnt + 1'b1;
                if (&fill_cnt)
                    busy_q <= 1'b0;  // Last address written
            end
        end
    end

    assign wr_en     = busy_q;
    assign wr_addr   = buf_addr_t'(fill_cnt);
    assign wr_sample = sample_q;
    assign status    = '{busy: busy_q, wr_addr: wr_addr};

    a_wr_addr_in_range: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        wr_en |-> 32'(wr_addr) < DEPTH);

endmodule

`default_nettype wire

//--- sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_buffer
    import radio_signal_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 12
)
(
    input  wire         led_clk,
    input  wire         wr_en,
    input  wire  buf_addr_t   wr_addr,
    input  wire  adc_sample_t wr_sample,
    input  wire  buf_addr_t   rd_addr,
    output adc_sample_t rd_sample
);
    localparam int DEPTH = 1 << BUF_ADDR_WIDTH;

    adc_sample_t mem [DEPTH];

    always_ff @(posedge led_clk)
    begin
        if (wr_en)
            mem[wr_addr[BUF_ADDR_WIDTH-1:0]] <= wr_sample;
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge led_clk)
    begin
        rd_sample <= mem[rd_addr[BUF_ADDR_WIDTH-1:0]];
    end

endmodule

`default_nettype wire

//--- irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
    import radio_signal_pkg::*;
(
    input  wire           led_clk,
    input  wire           adc_dpram_rst,
    input  wire irq_vec_t irq_lines,
    input  wire irq_cfg_t cfg,
    output irq_vec_t      irq_state,
    output logic          smc_irq_n,
    output logic          dsp_irq_n
);
    irq_vec_t lines_q;
    irq_vec_t rise;

    // Previous line levels, also tracked during reset
    always_ff @(posedge led_clk)
    begin
        lines_q <= irq_lines;
    end

    assign rise = irq_lines & ~lines_q;

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            irq_state <= '0;
        else
            irq_state <= (irq_state & ~cfg.clr_req) | rise | cfg.set_req;  // Set wins
    end

    // Active low, any masked pending line
    assign smc_irq_n = ~|(irq_state & cfg.mask0);
    assign dsp_irq_n = ~|(irq_state & cfg.mask1);

    a_state_clear_after_reset: assert property (@(posedge led_clk)
        $fell(adc_dpram_rst) |=> irq_state == '0);

endmodule

`default_nettype wire

//--- led_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module led_pwm
    import radio_signal_pkg::*;
#(
    parameter int LED_PWM_WIDTH = 12
)
(
    input  wire           led_clk,
    input  wire           adc_dpram_rst,
    input  wire led_cfg_t cfg,
    output logic          red_led,
    output logic          green_led,
    output logic          blue_led
);
    localparam int CHANNELS = 3;

    logic [LED_PWM_WIDTH-1:0] pwm_cnt;
    logic [LED_PWM_WIDTH-1:0] duty [CHANNELS];
    logic [CHANNELS-1:0]      led_q;

    // Modules use the low bits of the duty fields
    assign duty[0] = cfg.red_duty[LED_PWM_WIDTH-1:0];
    assign duty[1] = cfg.green_duty[LED_PWM_WIDTH-1:0];
    assign duty[2] = cfg.blue_duty[LED_PWM_WIDTH-1:0];

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst || !cfg.enable)
            pwm_cnt <= '0;
        else
            pwm_cnt <= pwm_cnt + 1'b1;
    end

    // High from the cycle after count zero through the cycle where count equals duty
    for (genvar i = 0; i < CHANNELS; i++)
    begin : g_chan
        always_ff @(posedge led_clk)
        begin
            if (adc_dpram_rst || !cfg.enable || duty[i] == '0)
                led_q[i] <= 1'b0;
            else if (pwm_cnt == '0)
                led_q[i] <= 1'b1;
            else if (pwm_cnt == duty[i])
                led_q[i] <= 1'b0;
        end
    end

    assign red_led   = led_q[0];
    assign green_led = led_q[1];
    assign blue_led  = led_q[2];

endmodule

`default_nettype wire

//--- ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs
    import radio_regmap_pkg::*;
    import radio_signal_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 12
)
(
    input  wire              led_clk,
    input  wire              adc_dpram_rst,
    input  wire apb_req_t    apb_req,
    input  wire cap_status_t cap_status,
    input  wire adc_sample_t rd_sample,
    input  wire irq_vec_t    irq_state,
    output apb_rsp_t         apb_rsp,
    output irq_cfg_t         irq_cfg,
    output led_cfg_t         led_cfg,
    output logic             cap_trig,
    output buf_addr_t        rd_addr
);
    localparam int DUTY_COUNT = 3;

    reg_index_t index;
    logic       access;
    logic       wr_access;
    logic       rd_access;
    logic       mapped;
    apb_data_t  rdata;

    irq_vec_t                  mask0_q;
    irq_vec_t                  mask1_q;
    logic                      led_en_q;
    logic [LED_DUTY_WIDTH-1:0] duty_q [DUTY_COUNT];
    logic                      auto_inc_q;
    logic [BUF_ADDR_WIDTH-1:0] rd_addr_q;

    assign index     = apb_req.paddr[7:2];
    assign access    = apb_req.psel && apb_req.penable;  // Access phase
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            mask0_q    <= '0;
            mask1_q    <= '0;
            led_en_q   <= 1'b0;
            auto_inc_q <= 1'b0;
            rd_addr_q  <= '0;
            for (int i = 0; i < DUTY_COUNT; i++)
                duty_q[i] <= '0;
        end
        else
        begin
            if (wr_access)
            begin
                case (index)
                    REG_IRQ:
                    begin
                        mask0_q <= apb_req.pwdata[IRQ_MASK0_LSB +: IRQ_COUNT];
                        mask1_q <= apb_req.pwdata[IRQ_MASK1_LSB +: IRQ_COUNT];
                    end
                    REG_LED_CNTRL:
                        led_en_q <= apb_req.pwdata[LED_EN_BIT];
                    REG_RED_DUTY:
                        duty_q[0] <= apb_req.pwdata[LED_DUTY_WIDTH-1:0];
                    REG_GREEN_DUTY:
                        duty_q[1] <= apb_req.pwdata[LED_DUTY_WIDTH-1:0];
                    REG_BLUE_DUTY:
                        duty_q[2] <= apb_req.pwdata[LED_DUTY_WIDTH-1:0];
                    REG_CAP_CNTRL:
                        auto_inc_q <= apb_req.pwdata[CAP_AUTO_INC_BIT];
                    REG_CAP_ADDR:
                        rd_addr_q <= apb_req.pwdata[CAP_RD_ADDR_LSB +: BUF_ADDR_WIDTH];
                    default:
                        ;  // ID, data and unmapped writes have no effect
                endcase
            end

            // Step to the next sample once this one is read
            if (rd_access && index == REG_CAP_DATA && auto_inc_q)
                rd_addr_q <= rd_addr_q + 1'b1;
        end
    end

    // Set, clear and trigger pulses come straight from the access cycle
    always_comb
    begin
        irq_cfg.mask0   = mask0_q;
        irq_cfg.mask1   = mask1_q;
        irq_cfg.set_req = '0;
        irq_cfg.clr_req = '0;
        if (wr_access && index == REG_IRQ)
        begin
            irq_cfg.set_req = apb_req.pwdata[IRQ_SET_LSB +: IRQ_COUNT];
            irq_cfg.clr_req = apb_req.pwdata[IRQ_STATE_LSB +: IRQ_COUNT];
        end
    end

    assign cap_trig = wr_access && index == REG_CAP_CNTRL && apb_req.pwdata[CAP_TRIG_BIT];
    assign led_cfg  = '{led_en_q, duty_q[0], duty_q[1], duty_q[2]};
    assign rd_addr  = buf_addr_t'(rd_addr_q);

    always_comb
    begin
        rdata  = '0;
        mapped = 1'b1;
        case (index)
            REG_ID:
                rdata = RADIO_ID;
            REG_IRQ:
            begin
                rdata[IRQ_MASK0_LSB +: IRQ_COUNT] = mask0_q;
                rdata[IRQ_MASK1_LSB +: IRQ_COUNT] = mask1_q;
                rdata[IRQ_STATE_LSB +: IRQ_COUNT] = irq_state;
            end
            REG_LED_CNTRL:
                rdata[LED_EN_BIT] = led_en_q;
            REG_RED_DUTY:
                rdata[LED_DUTY_WIDTH-1:0] = duty_q[0];
            REG_GREEN_DUTY:
                rdata[LED_DUTY_WIDTH-1:0] = duty_q[1];
            REG_BLUE_DUTY:
                rdata[LED_DUTY_WIDTH-1:0] = duty_q[2];
            REG_CAP_CNTRL:
            begin
                rdata[CAP_AUTO_INC_BIT] = auto_inc_q;  // Trigger reads back as zero
                rdata[CAP_BUSY_BIT]     = cap_status.busy;
            end
            REG_CAP_ADDR:
            begin
                rdata[CAP_RD_ADDR_LSB +: $bits(buf_addr_t)] = rd_addr;
                rdata[CAP_WR_ADDR_LSB +: $bits(buf_addr_t)] = cap_status.wr_addr;
            end
            REG_CAP_DATA:
                rdata = apb_data_t'(rd_sample);  // Overflow lands in bit 16
            default:
                mapped = 1'b0;
        endcase
    end

    // No wait states
    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && !mapped};

    a_penable_needs_psel: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        apb_req.penable |-> apb_req.psel);

    // Every access phase follows a setup phase
    a_setup_before_access: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        access |-> $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

//--- radio_core.sv
`timescale 1ns/1ps
`default_nettype none

module radio_core
    import radio_regmap_pkg::*;
    import radio_signal_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 12,
    parameter int LED_PWM_WIDTH  = 12
)
(
    input  wire           led_clk,
    input  wire           adc_dpram_rst,
    input  wire apb_req_t apb_req,
    input  wire    [15:0] adc_data,
    input  wire           adc_of,
    output apb_rsp_t      apb_rsp,
    output logic          adc_clk_en,
    output logic          smc_irq_n,
    output logic          dsp_irq_n,
    output logic          red_led,
    output logic          green_led,
    output logic          blue_led
);
    cap_status_t cap_status;
    logic        cap_trig;
    logic        wr_en;
    buf_addr_t   wr_addr;
    buf_addr_t   rd_addr;
    adc_sample_t wr_sample;
    adc_sample_t rd_sample;
    irq_cfg_t    irq_cfg;
    irq_vec_t    irq_lines;
    irq_vec_t    irq_state;
    led_cfg_t    led_cfg;

    // Line 0 capture running, line 1 capture idle
    assign irq_lines = {{(IRQ_COUNT - 2){1'b0}}, ~cap_status.busy, cap_status.busy};

    adc_capture #(.BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) i_adc_capture (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .adc_data      (adc_data),
        .adc_of        (adc_of),
        .trig          (cap_trig),
        .adc_clk_en    (adc_clk_en),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_sample     (wr_sample),
        .status        (cap_status)
    );

    sample_buffer #(.BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) i_sample_buffer (
        .led_clk   (led_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_sample (wr_sample),
        .rd_addr   (rd_addr),
        .rd_sample (rd_sample)
    );

    ctrl_regs #(.BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) i_ctrl_regs (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .apb_req       (apb_req),
        .cap_status    (cap_status),
        .rd_sample     (rd_sample),
        .irq_state     (irq_state),
        .apb_rsp       (apb_rsp),
        .irq_cfg       (irq_cfg),
        .led_cfg       (led_cfg),
        .cap_trig      (cap_trig),
        .rd_addr       (rd_addr)
    );

    irq_ctrl i_irq_ctrl (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .irq_lines     (irq_lines),
        .cfg           (irq_cfg),
        .irq_state     (irq_state),
        .smc_irq_n     (smc_irq_n),
        .dsp_irq_n     (dsp_irq_n)
    );

    led_pwm #(.LED_PWM_WIDTH(LED_PWM_WIDTH)) i_led_pwm (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .cfg           (led_cfg),
        .red_led       (red_led),
        .green_led     (green_led),
        .blue_led      (blue_led)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
)
(
    output logic led_clk,
    output logic adc_dpram_rst
);
    initial
    begin
        led_clk = 1'b0;
        forever
            #(PERIOD_NS / 2) led_clk = ~led_clk;
    end

    // Released 1 ns after the last reset edge
    initial
    begin
        adc_dpram_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge led_clk);
        #1;
        adc_dpram_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_radio_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_radio_core
    import radio_regmap_pkg::*;
    import radio_signal_pkg::*;
();
    localparam int BUF_AW         = 6;
    localparam int PWM_W          = 6;
    localparam int DEPTH          = 1 << BUF_AW;
    localparam int PWM_PERIOD     = 1 << PWM_W;
    localparam int TIMEOUT_CYCLES = 200;

    logic        led_clk;
    logic        adc_dpram_rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [15:0] adc_data;
    logic        adc_of;
    logic        adc_clk_en;
    logic        smc_irq_n;
    logic        dsp_irq_n;
    logic        red_led;
    logic        green_led;
    logic        blue_led;

    int     n_checks;
    int     n_errors;
    int     test_checks;
    int     test_errors;
    integer seed;

    // Expected register contents
    irq_vec_t                  sh_mask0;
    irq_vec_t                  sh_mask1;
    irq_vec_t                  sh_state;
    logic                      sh_led_en;
    logic [LED_DUTY_WIDTH-1:0] sh_duty [3];
    logic                      sh_auto_inc;
    logic [BUF_AW-1:0]         sh_rd_addr;

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(2)) i_clk_gen (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst)
    );

    radio_core #(.BUF_ADDR_WIDTH(BUF_AW), .LED_PWM_WIDTH(PWM_W)) i_radio_core (
        .led_clk       (led_clk),
        .adc_dpram_rst (adc_dpram_rst),
        .apb_req       (apb_req),
        .adc_data      (adc_data),
        .adc_of        (adc_of),
        .apb_rsp       (apb_rsp),
        .adc_clk_en    (adc_clk_en),
        .smc_irq_n     (smc_irq_n),
        .dsp_irq_n     (dsp_irq_n),
        .red_led       (red_led),
        .green_led     (green_led),
        .blue_led      (blue_led)
    );

    // ADC ramp, overflow follows data bit 0
    initial
    begin
        adc_data = '0;
        adc_of   = 1'b0;
        forever
        begin
            @(posedge led_clk);
            #1;
            adc_data = adc_data + 16'd1;
            adc_of   = adc_data[0];
        end
    end

    function automatic apb_data_t ref_read(input reg_index_t idx);
        apb_data_t v;
        v = '0;
        case (idx)
            REG_ID:
                v = RADIO_ID;
            REG_IRQ:
                v = {8'h00, sh_state, sh_mask1, sh_mask0};
            REG_LED_CNTRL:
                v[0] = sh_led_en;
            REG_RED_DUTY, REG_GREEN_DUTY, REG_BLUE_DUTY:
                v[11:0] = sh_duty[idx - REG_RED_DUTY];
            REG_CAP_CNTRL:
                v[1] = sh_auto_inc;  // Idle, busy low
            REG_CAP_ADDR:
                v[15:0] = 16'(sh_rd_addr);  // Writer parked at 0
            default:
                v = '0;
        endcase
        return v;
    endfunction

    task automatic update_shadow(input reg_index_t idx, input apb_data_t data);
        case (idx)
            REG_IRQ:
            begin
                sh_mask0 = data[7:0];
                sh_mask1 = data[15:8];
                sh_state = (sh_state & ~data[23:16]) | data[31:24];
            end
            REG_LED_CNTRL:
                sh_led_en = data[0];
            REG_RED_DUTY, REG_GREEN_DUTY, REG_BLUE_DUTY:
                sh_duty[idx - REG_RED_DUTY] = data[11:0];
            REG_CAP_CNTRL:
                sh_auto_inc = data[1];
            REG_CAP_ADDR:
                sh_rd_addr = data[BUF_AW-1:0];
            default:
                ;
        endcase
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input adc_sample_t got,
                                input adc_sample_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic finish_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, n_checks - test_checks,
                 n_errors - test_errors);
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    // One APB transfer, setup then access, followed by an idle cycle
    task automatic apb_xfer(input logic write, input reg_index_t idx, input apb_data_t wdata,
                            output apb_data_t rdata, output logic slverr);
        int waited;
        @(posedge led_clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: {idx, 2'b00},
                    pwdata: wdata};
        @(posedge led_clk);
        #1;
        apb_req.penable = 1'b1;
        #1;
        waited = 0;
        while (!apb_rsp.pready && waited < TIMEOUT_CYCLES)
        begin
            @(posedge led_clk);
            #2;
            waited++;
        end
        if (!apb_rsp.pready)
            report_timeout("APB pready");
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge led_clk);
        #1;
        apb_req = '0;
        #1;
    endtask

    task automatic write_reg(input reg_index_t idx, input apb_data_t data);
        apb_data_t unused;
        logic      slverr;
        apb_xfer(1'b1, idx, data, unused, slverr);
        check_bit("pslverr", slverr, 1'b0);
        update_shadow(idx, data);
    endtask

    task automatic read_reg(input reg_index_t idx, output apb_data_t data);
        logic slverr;
        apb_xfer(1'b0, idx, '0, data, slverr);
        check_bit("pslverr", slverr, 1'b0);
    endtask

    task automatic read_expect(input string name, input reg_index_t idx);
        apb_data_t data;
        read_reg(idx, data);
        check_word(name, data, ref_read(idx));
    endtask

    initial
    begin
        apb_data_t   data;
        apb_data_t   rnd;
        logic        slverr;
        adc_sample_t sample;
        adc_sample_t exp_sample;
        logic [PWM_W-1:0] led_duty [3];
        int          led_cnt [3];
        int          cycles;

        apb_req     = '0;
        seed        = 32'h4abbec4b;
        n_checks    = 0;
        n_errors    = 0;
        test_checks = 0;
        test_errors = 0;
        sh_mask0    = '0;
        sh_mask1    = '0;
        sh_state    = '0;
        sh_led_en   = 1'b0;
        sh_auto_inc = 1'b0;
        sh_rd_addr  = '0;
        for (int i = 0; i < 3; i++)
            sh_duty[i] = '0;

        cycles = 0;
        while (adc_dpram_rst !== 1'b0 && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge led_clk);
            cycles++;
        end
        if (adc_dpram_rst !== 1'b0)
            report_timeout("reset release");

        // Reset values
        read_expect("id", REG_ID);
        read_expect("irq", REG_IRQ);
        read_expect("led_cntrl", REG_LED_CNTRL);
        for (int i = 0; i < 3; i++)
            read_expect("duty", reg_index_t'(REG_RED_DUTY + i));
        read_expect("cap_cntrl", REG_CAP_CNTRL);
        read_expect("cap_addr", REG_CAP_ADDR);
        check_bit("adc_clk_en", adc_clk_en, 1'b1);
        check_bit("smc_irq_n", smc_irq_n, 1'b1);
        check_bit("dsp_irq_n", dsp_irq_n, 1'b1);
        check_bit("red_led", red_led, 1'b0);
        check_bit("green_led", green_led, 1'b0);
        check_bit("blue_led", blue_led, 1'b0);
        apb_xfer(1'b0, 6'h3F, '0, data, slverr);  // Unmapped
        check_bit("pslverr unmapped", slverr, 1'b1);
        check_word("prdata unmapped", data, '0);
        finish_test("reset values");

        for (int i = 0; i < 3; i++)
        begin
            rnd = $random(seed);
            write_reg(reg_index_t'(REG_RED_DUTY + i), rnd);
            read_expect("duty", reg_index_t'(REG_RED_DUTY + i));
        end
        rnd = $random(seed);
        write_reg(REG_LED_CNTRL, rnd & 32'hFFFF_FFFE);  // LEDs stay off
        read_expect("led_cntrl", REG_LED_CNTRL);
        rnd = $random(seed);
        write_reg(REG_IRQ, {8'h00, 8'hFF, rnd[15:0]});  // Clear only
        read_expect("irq", REG_IRQ);
        rnd = $random(seed);
        write_reg(REG_CAP_ADDR, rnd);
        read_expect("cap_addr", REG_CAP_ADDR);
        rnd = $random(seed);
        write_reg(REG_CAP_CNTRL, rnd & 32'hFFFF_FFFE);  // No trigger
        read_expect("cap_cntrl", REG_CAP_CNTRL);
        rnd = $random(seed);
        write_reg(REG_ID, rnd);
        read_expect("id", REG_ID);
        finish_test("register readback");

        // One buffer fill, then a full read with auto-increment
        write_reg(REG_CAP_ADDR, 32'h0);
        write_reg(REG_CAP_CNTRL, 32'h3);
        read_reg(REG_CAP_CNTRL, data);
        check_bit("busy", data[CAP_BUSY_BIT], 1'b1);
        cycles = 0;
        while (data[CAP_BUSY_BIT] && cycles < TIMEOUT_CYCLES)
        begin
            read_reg(REG_CAP_CNTRL, data);
            cycles++;
        end
        if (data[CAP_BUSY_BIT])
            report_timeout("capture busy to clear");
        sh_state = sh_state | 8'h03;  // Busy rose, then fell
        read_expect("cap_cntrl", REG_CAP_CNTRL);
        exp_sample = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            read_reg(REG_CAP_DATA, data);
            sh_rd_addr = sh_rd_addr + 1'b1;
            sample     = adc_sample_t'(data[16:0]);
            check_word("cap_data upper", data & 32'hFFFE_0000, '0);
            if (i == 0)
                exp_sample.data = sample.data;  // Ramp start is free
            else
                exp_sample.data = exp_sample.data + 16'd1;
            exp_sample.overflow = exp_sample.data[0];
            check_sample("cap_data", sample, exp_sample);
        end
        read_expect("cap_addr", REG_CAP_ADDR);
        read_expect("irq", REG_IRQ);
        finish_test("capture");

        write_reg(REG_IRQ, 32'h00FF_2002);  // mask0 line 1, mask1 line 5
        check_bit("smc_irq_n", smc_irq_n, 1'b1);
        check_bit("dsp_irq_n", dsp_irq_n, 1'b1);
        read_expect("irq", REG_IRQ);
        write_reg(REG_CAP_CNTRL, 32'h3);
        cycles = 0;
        while (smc_irq_n && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge led_clk);
            #2;
            cycles++;
        end
        if (smc_irq_n)
            report_timeout("smc_irq_n to go low");
        sh_state = sh_state | 8'h03;
        read_expect("cap_cntrl", REG_CAP_CNTRL);
        read_expect("irq", REG_IRQ);
        check_bit("dsp_irq_n", dsp_irq_n, 1'b1);
        write_reg(REG_IRQ, 32'h0002_2002);
        check_bit("smc_irq_n", smc_irq_n, 1'b1);
        write_reg(REG_IRQ, 32'h2000_2002);  // Set line 5
        check_bit("dsp_irq_n", dsp_irq_n, 1'b0);
        check_bit("smc_irq_n", smc_irq_n, 1'b1);
        read_expect("irq", REG_IRQ);
        finish_test("interrupts");

        write_reg(REG_LED_CNTRL, 32'h0);
        for (int c = 0; c < 3; c++)
        begin
            rnd         = $random(seed);
            led_duty[c] = (c == 2) ? '0 : PWM_W'(rnd % 63 + 1);
            write_reg(reg_index_t'(REG_RED_DUTY + c), {rnd[31:PWM_W], led_duty[c]});
        end
        write_reg(REG_LED_CNTRL, 32'h1);
        read_expect("led_cntrl", REG_LED_CNTRL);
        rnd = $random(seed);
        repeat (PWM_PERIOD + rnd % PWM_PERIOD) @(posedge led_clk);
        led_cnt = '{0, 0, 0};
        repeat (PWM_PERIOD)
        begin
            @(posedge led_clk);
            #2;
            led_cnt[0] += int'(red_led);
            led_cnt[1] += int'(green_led);
            led_cnt[2] += int'(blue_led);
        end
        for (int c = 0; c < 3; c++)
            check_word($sformatf("led %0d high cycles", c), apb_data_t'(led_cnt[c]),
                       apb_data_t'(led_duty[c]));
        finish_test("led pwm");

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- radio_core.f
radio_regmap_pkg.sv
radio_signal_pkg.sv
adc_capture.sv
sample_buffer.sv
irq_ctrl.sv
led_pwm.sv
ctrl_regs.sv
radio_core.sv
tb_clk_gen.sv
tb_radio_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_radio_core -f radio_core.f -o tb_radio_core
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_radio_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
